// ==== verilog/pio_pkg.sv ====
package pio_pkg;

  // one bank of pins
  parameter int PIO_PINS = 32;

  // APB bus widths
  typedef logic [7:0]  apb_addr_t;  // byte address
  typedef logic [31:0] apb_data_t;  // data word

  // one bit per pin
  typedef logic [PIO_PINS-1:0] pin_vec_t;

  // two select bits per pin, pin n in bits 2n+1:2n
  typedef logic [2*PIO_PINS-1:0] msel_vec_t;

  // pin function select
  typedef enum logic [1:0] {
    FUNC_GPIO = 2'd0,  // plain gpio, dir is the output enable
    FUNC_ALT1 = 2'd1,  // alternate 1, always driven
    FUNC_ALT2 = 2'd2,  // alternate 2, own enable
    FUNC_ALT3 = 2'd3   // alternate 3, own enable
  } pin_func_e;

  // writable registers
  parameter apb_addr_t ADDR_OUT     = 8'h00;
  parameter apb_addr_t ADDR_DIR     = 8'h04;
  parameter apb_addr_t ADDR_MSEL_LO = 8'h08;  // pins 0 to 15
  parameter apb_addr_t ADDR_MSEL_HI = 8'h0C;  // pins 16 to 31

  // read only, synchronized pad inputs
  parameter apb_addr_t ADDR_IN      = 8'h10;

endpackage

// ==== verilog/reset_stretch.sv ====
`timescale 1ns/1ps

module reset_stretch #(
  parameter int RST_CNT_BITS = 6
) (
  input  logic wMEM_CLK,
  input  logic reset_i,
  output logic sys_rst_o
);

  logic [RST_CNT_BITS-1:0] cnt_q;

  // counts up once reset_i drops, parks when the top bit sets
  always_ff @(posedge wMEM_CLK)
  begin
    if (reset_i)
    begin
      cnt_q <= '0;
    end
    else if (!cnt_q[RST_CNT_BITS-1])
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign sys_rst_o = ~cnt_q[RST_CNT_BITS-1];  // held until top bit

endmodule

// ==== verilog/pio_apb_regs.sv ====
`timescale 1ns/1ps

module pio_apb_regs (
  input  logic                wMEM_CLK,
  input  logic                sys_rst_i,

  // APB slave
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  pio_pkg::apb_addr_t  paddr_i,
  input  pio_pkg::apb_data_t  pwdata_i,
  output logic                pready_o,
  output pio_pkg::apb_data_t  prdata_o,
  output logic                pslverr_o,

  // pad side
  input  pio_pkg::pin_vec_t   pad_in_i,
  output pio_pkg::pin_vec_t   pio_out_o,
  output pio_pkg::pin_vec_t   pio_dir_o,
  output pio_pkg::msel_vec_t  pio_msel_o
);

  import pio_pkg::*;

  logic      ready;      // slave can complete an access
  logic      access;     // access phase
  logic      done;       // completing edge
  logic      wr_hit;     // writable offset
  logic      rd_hit;     // readable offset
  logic      wr_en;
  apb_data_t rd_data;

  pin_vec_t  out_q;
  pin_vec_t  dir_q;
  apb_data_t msel_lo_q;
  apb_data_t msel_hi_q;
  pin_vec_t  sync1_q;    // first synchronizer stage
  pin_vec_t  sync2_q;    // stable copy of pad_in_i

  assign ready  = ~sys_rst_i;  // waits out the stretched reset
  assign access = psel_i & penable_i;
  assign done   = access & ready;

  // address decode
  always_comb
  begin
    wr_hit = 1'b0;
    rd_hit = 1'b1;
    rd_data = '0;  // unmapped reads return zero
    case (paddr_i)
      ADDR_OUT:
      begin
        wr_hit  = 1'b1;
        rd_data = out_q;
      end
      ADDR_DIR:
      begin
        wr_hit  = 1'b1;
        rd_data = dir_q;
      end
      ADDR_MSEL_LO:
      begin
        wr_hit  = 1'b1;
        rd_data = msel_lo_q;
      end
      ADDR_MSEL_HI:
      begin
        wr_hit  = 1'b1;
        rd_data = msel_hi_q;
      end
      ADDR_IN:
      begin
        rd_data = sync2_q;  // read only
      end
      default:
      begin
        rd_hit = 1'b0;
      end
    endcase
  end

  assign wr_en = done & pwrite_i & wr_hit;

  // register file
  always_ff @(posedge wMEM_CLK)
  begin
    if (sys_rst_i)
    begin
      out_q     <= '0;
      dir_q     <= '0;  // all pins inputs
      msel_lo_q <= '0;  // all pins gpio
      msel_hi_q <= '0;
    end
    else if (wr_en)
    begin
      case (paddr_i)
        ADDR_OUT:     out_q     <= pwdata_i;
        ADDR_DIR:     dir_q     <= pwdata_i;
        ADDR_MSEL_LO: msel_lo_q <= pwdata_i;
        ADDR_MSEL_HI: msel_hi_q <= pwdata_i;
        default:      ;
      endcase
    end
  end

  // two flop synchronizer on the pad inputs
  always_ff @(posedge wMEM_CLK)
  begin
    if (sys_rst_i)
    begin
      sync1_q <= '0;
      sync2_q <= '0;
    end
    else
    begin
      sync1_q <= pad_in_i;
      sync2_q <= sync1_q;
    end
  end

  assign pready_o  = ready;
  assign prdata_o  = (access & ~pwrite_i) ? rd_data : '0;
  assign pslverr_o = done & (pwrite_i ? ~wr_hit : ~rd_hit);  // IN is not writable

  assign pio_out_o  = out_q;
  assign pio_dir_o  = dir_q;
  assign pio_msel_o = {msel_hi_q, msel_lo_q};

endmodule

// ==== verilog/pin_mux.sv ====
`timescale 1ns/1ps

module pin_mux (
  input  pio_pkg::pin_vec_t  pio_out_i,
  input  pio_pkg::pin_vec_t  pio_dir_i,
  input  pio_pkg::msel_vec_t pio_msel_i,
  input  pio_pkg::pin_vec_t  alt1_out_i,
  input  pio_pkg::pin_vec_t  alt2_out_i,
  input  pio_pkg::pin_vec_t  alt2_oe_i,
  input  pio_pkg::pin_vec_t  alt3_out_i,
  input  pio_pkg::pin_vec_t  alt3_oe_i,
  output pio_pkg::pin_vec_t  pad_out_o,
  output pio_pkg::pin_vec_t  pad_oe_o
);

  import pio_pkg::*;

  for (genvar i = 0; i < PIO_PINS; i++)
  begin : g_pin
    pin_func_e func;
    logic      out_sel;
    logic      oe_sel;

    assign func = pin_func_e'(pio_msel_i[2*i +: 2]);  // this pin's field

    always_comb
    begin
      out_sel = 1'b0;
      oe_sel  = 1'b0;
      case (func)
        FUNC_GPIO:
        begin
          out_sel = pio_out_i[i];
          oe_sel  = pio_dir_i[i];
        end
        FUNC_ALT1:
        begin
          out_sel = alt1_out_i[i];
          oe_sel  = 1'b1;  // always driven
        end
        FUNC_ALT2:
        begin
          out_sel = alt2_out_i[i];
          oe_sel  = alt2_oe_i[i];
        end
        FUNC_ALT3:
        begin
          out_sel = alt3_out_i[i];
          oe_sel  = alt3_oe_i[i];
        end
        default:
        begin
          oe_sel = 1'b0;
        end
      endcase
    end

    assign pad_oe_o[i]  = oe_sel;
    assign pad_out_o[i] = oe_sel & out_sel;  // quiet when not driven
  end

endmodule

// ==== verilog/pio_top.sv ====
`timescale 1ns/1ps

module pio_top #(
  parameter int RST_CNT_BITS = 6  // stretch is 2**(RST_CNT_BITS-1) cycles
) (
  input  logic               wMEM_CLK,
  input  logic               reset_i,

  // APB slave
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  pio_pkg::apb_addr_t paddr_i,
  input  pio_pkg::apb_data_t pwdata_i,
  output logic               pready_o,
  output pio_pkg::apb_data_t prdata_o,
  output logic               pslverr_o,

  // pads
  input  pio_pkg::pin_vec_t  pad_in_i,
  output pio_pkg::pin_vec_t  pad_out_o,
  output pio_pkg::pin_vec_t  pad_oe_o,

  // alternate sources
  input  pio_pkg::pin_vec_t  alt1_out_i,
  input  pio_pkg::pin_vec_t  alt2_out_i,
  input  pio_pkg::pin_vec_t  alt2_oe_i,
  input  pio_pkg::pin_vec_t  alt3_out_i,
  input  pio_pkg::pin_vec_t  alt3_oe_i
);

  import pio_pkg::*;

  logic      sys_rst;   // stretched reset
  pin_vec_t  pio_out;
  pin_vec_t  pio_dir;
  msel_vec_t pio_msel;

  reset_stretch #(
    .RST_CNT_BITS (RST_CNT_BITS)
  ) i_reset_stretch (
    .wMEM_CLK  (wMEM_CLK),
    .reset_i   (reset_i),
    .sys_rst_o (sys_rst)
  );

  pio_apb_regs i_pio_apb_regs (
    .wMEM_CLK   (wMEM_CLK),
    .sys_rst_i  (sys_rst),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .pad_in_i   (pad_in_i),
    .pready_o   (pready_o),
    .prdata_o   (prdata_o),
    .pslverr_o  (pslverr_o),
    .pio_out_o  (pio_out),
    .pio_dir_o  (pio_dir),
    .pio_msel_o (pio_msel)
  );

  pin_mux i_pin_mux (
    .pio_out_i  (pio_out),
    .pio_dir_i  (pio_dir),
    .pio_msel_i (pio_msel),
    .alt1_out_i (alt1_out_i),
    .alt2_out_i (alt2_out_i),
    .alt2_oe_i  (alt2_oe_i),
    .alt3_out_i (alt3_out_i),
    .alt3_oe_i  (alt3_oe_i),
    .pad_out_o  (pad_out_o),
    .pad_oe_o   (pad_oe_o)
  );

endmodule

// ==== verification/pio_assertions.sv ====
`timescale 1ns/1ps

module pio_assertions (
  input logic               wMEM_CLK,
  input logic               sys_rst_i,
  input logic               psel_i,
  input logic               penable_i,
  input logic               pwrite_i,
  input pio_pkg::apb_addr_t paddr_i,
  input pio_pkg::apb_data_t pwdata_i,
  input logic               pready_i,
  input logic               pslverr_i
);

  int fail_cnt = 0;  // read by the testbench at the end

  // slave holds off the bus during the stretched reset
  a_reset_state: assert property (@(posedge wMEM_CLK) sys_rst_i |-> (!pready_i && !pslverr_i))
  else
  begin
    $error("pready or pslverr high during reset");
    fail_cnt++;
  end

  a_err_on_done: assert property (@(posedge wMEM_CLK)
    pslverr_i |-> (psel_i && penable_i && pready_i))
  else
  begin
    $error("pslverr outside a completing access phase");
    fail_cnt++;
  end

  // setup phase moves to access with the same request
  a_setup_stable: assert property (@(posedge wMEM_CLK) (psel_i && !penable_i) |=>
    (psel_i && penable_i && $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i)))
  else
  begin
    $error("APB request changed between setup and access");
    fail_cnt++;
  end

  a_wait_stable: assert property (@(posedge wMEM_CLK) (psel_i && penable_i && !pready_i) |=>
    (psel_i && penable_i && $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i)))
  else
  begin
    $error("APB request changed while waiting for pready");
    fail_cnt++;
  end

endmodule

bind pio_apb_regs pio_assertions i_assertions (
  .wMEM_CLK  (wMEM_CLK),
  .sys_rst_i (sys_rst_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pwrite_i  (pwrite_i),
  .paddr_i   (paddr_i),
  .pwdata_i  (pwdata_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o)
);

// ==== verification/pio_checker.sv ====
`timescale 1ns/1ps

module pio_checker (
  input  logic               wMEM_CLK,
  input  logic               reset_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  pio_pkg::apb_addr_t paddr_i,
  input  pio_pkg::apb_data_t pwdata_i,
  input  logic               pready_i,
  input  pio_pkg::apb_data_t prdata_i,
  input  logic               pslverr_i,
  input  pio_pkg::pin_vec_t  pad_in_i,
  input  pio_pkg::pin_vec_t  pad_out_i,
  input  pio_pkg::pin_vec_t  pad_oe_i,
  input  pio_pkg::pin_vec_t  alt1_out_i,
  input  pio_pkg::pin_vec_t  alt2_out_i,
  input  pio_pkg::pin_vec_t  alt2_oe_i,
  input  pio_pkg::pin_vec_t  alt3_out_i,
  input  pio_pkg::pin_vec_t  alt3_oe_i,
  output int                 pad_err_o,
  output int                 rd_err_o,
  output int                 rst_err_o,
  output int                 xfer_cnt_o
);

  import pio_pkg::*;

  localparam int STRETCH = 32;  // reset_stretch hold time in cycles

  pin_vec_t  out_m = '0;  // shadow registers
  pin_vec_t  dir_m = '0;
  apb_data_t msel_lo_m = '0;
  apb_data_t msel_hi_m = '0;
  pin_vec_t  in_d1 = '0;  // pad_in one and two cycles back
  pin_vec_t  in_d2 = '0;
  logic      seen_rst = 1'b0;
  logic      released = 1'b0;
  logic      checking = 1'b0;
  int        low_cnt = 0;

  initial
  begin
    pad_err_o  = 0;
    rd_err_o   = 0;
    rst_err_o  = 0;
    xfer_cnt_o = 0;
  end

  // expected {oe, out} for every pin
  function automatic logic [2*PIO_PINS-1:0] pad_expect(input pin_vec_t out_r, input pin_vec_t dir_r,
      input msel_vec_t msel, input pin_vec_t a1, input pin_vec_t a2, input pin_vec_t a2_oe,
      input pin_vec_t a3, input pin_vec_t a3_oe);
    pin_vec_t drv;
    pin_vec_t oe;
    drv = '0;
    oe  = '0;
    for (int i = 0; i < PIO_PINS; i++)
    begin
      case (pin_func_e'(msel[2*i +: 2]))
        FUNC_GPIO:
        begin
          drv[i] = out_r[i];
          oe[i]  = dir_r[i];
        end
        FUNC_ALT1:
        begin
          drv[i] = a1[i];
          oe[i]  = 1'b1;
        end
        FUNC_ALT2:
        begin
          drv[i] = a2[i];
          oe[i]  = a2_oe[i];
        end
        FUNC_ALT3:
        begin
          drv[i] = a3[i];
          oe[i]  = a3_oe[i];
        end
      endcase
    end
    return {oe, drv & oe};
  endfunction

  // everything is sampled mid cycle, away from both edges
  always @(negedge wMEM_CLK)
  begin : compare
    logic [2*PIO_PINS-1:0] exp_pads;
    apb_data_t             exp_rd;
    logic                  writable;
    logic                  exp_err;
    if (reset_i)
    begin
      seen_rst = 1'b1;
      low_cnt  = 0;
    end
    else if (seen_rst && !released)
    begin
      if (!pready_i)
      begin
        low_cnt++;
      end
      else
      begin
        released = 1'b1;
        if (low_cnt != STRETCH)
        begin
          $display("error at %0t: pready low for %0d cycles, expected %0d", $time, low_cnt,
                   STRETCH);
          rst_err_o++;
        end
      end
    end
    else if (released && !pready_i)
    begin
      $display("error at %0t: wait state after reset release", $time);
      rst_err_o++;
    end
    if (!pready_i && pad_oe_i !== '0)
    begin
      $display("error at %0t: pad_oe %h during reset", $time, pad_oe_i);
      rst_err_o++;
    end
    exp_pads = pad_expect(out_m, dir_m, {msel_hi_m, msel_lo_m}, alt1_out_i, alt2_out_i,
                          alt2_oe_i, alt3_out_i, alt3_oe_i);
    if (checking && {pad_oe_i, pad_out_i} !== exp_pads)
    begin
      $display("error at %0t: pads oe %h out %h, expected oe %h out %h", $time, pad_oe_i,
               pad_out_i, exp_pads[2*PIO_PINS-1:PIO_PINS], exp_pads[PIO_PINS-1:0]);
      pad_err_o++;
    end
    if (psel_i && penable_i && pready_i)  // completes on the coming edge
    begin
      checking = 1'b1;
      xfer_cnt_o++;
      writable = (paddr_i == ADDR_OUT) || (paddr_i == ADDR_DIR) ||
                 (paddr_i == ADDR_MSEL_LO) || (paddr_i == ADDR_MSEL_HI);
      exp_err  = pwrite_i ? !writable : !(writable || paddr_i == ADDR_IN);
      exp_rd   = '0;
      case (paddr_i)
        ADDR_OUT:     exp_rd = out_m;
        ADDR_DIR:     exp_rd = dir_m;
        ADDR_MSEL_LO: exp_rd = msel_lo_m;
        ADDR_MSEL_HI: exp_rd = msel_hi_m;
        ADDR_IN:      exp_rd = in_d2;  // two flop delay
        default:      exp_rd = '0;
      endcase
      if (pslverr_i !== exp_err)
      begin
        $display("error at %0t: pslverr %b at offset %h, expected %b", $time, pslverr_i,
                 paddr_i, exp_err);
        rd_err_o++;
      end
      if (!pwrite_i && prdata_i !== exp_rd)
      begin
        $display("error at %0t: read %h at offset %h, expected %h", $time, prdata_i, paddr_i,
                 exp_rd);
        rd_err_o++;
      end
      if (pwrite_i && writable)
      begin
        case (paddr_i)
          ADDR_OUT:     out_m = pwdata_i;
          ADDR_DIR:     dir_m = pwdata_i;
          ADDR_MSEL_LO: msel_lo_m = pwdata_i;
          default:      msel_hi_m = pwdata_i;
        endcase
      end
    end
    in_d2 = in_d1;
    in_d1 = pad_in_i;
  end

endmodule

// ==== verification/pio_tb.sv ====
`timescale 1ns/1ps

module pio_tb;

  import pio_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int SEED         = 10460;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_XFERS    = 2000;
  localparam int N_READBACK   = 40;
  localparam int N_GPIO       = 40;
  localparam int N_ALT        = 50;
  localparam int ALT_HOLD     = 20;  // cycles per msel setting
  localparam int N_INPUT      = 10;
  localparam int TIMEOUT_NS   = MAX_XFERS * 4 * CLK_PERIOD + (RESET_CYCLES + 32) * CLK_PERIOD;

  logic      wMEM_CLK;
  logic      reset_i;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  logic      pready;
  apb_data_t prdata;
  logic      pslverr;
  pin_vec_t  pad_in;
  pin_vec_t  pad_out;
  pin_vec_t  pad_oe;
  pin_vec_t  alt1_out;
  pin_vec_t  alt2_out;
  pin_vec_t  alt2_oe;
  pin_vec_t  alt3_out;
  pin_vec_t  alt3_oe;
  logic      alt_run;
  logic [31:0] rnd_state;
  logic [31:0] alt_state;
  int        issued;
  int        pad_err;
  int        rd_err;
  int        rst_err;
  int        xfer_cnt;
  apb_addr_t wr_addrs [4] = '{ADDR_OUT, ADDR_DIR, ADDR_MSEL_LO, ADDR_MSEL_HI};

  pio_top i_dut (
    .wMEM_CLK (wMEM_CLK), .reset_i (reset_i),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .pready_o (pready), .prdata_o (prdata), .pslverr_o (pslverr),
    .pad_in_i (pad_in), .pad_out_o (pad_out), .pad_oe_o (pad_oe),
    .alt1_out_i (alt1_out), .alt2_out_i (alt2_out), .alt2_oe_i (alt2_oe),
    .alt3_out_i (alt3_out), .alt3_oe_i (alt3_oe)
  );

  pio_checker i_checker (
    .wMEM_CLK (wMEM_CLK), .reset_i (reset_i),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .pready_i (pready), .prdata_i (prdata), .pslverr_i (pslverr),
    .pad_in_i (pad_in), .pad_out_i (pad_out), .pad_oe_i (pad_oe),
    .alt1_out_i (alt1_out), .alt2_out_i (alt2_out), .alt2_oe_i (alt2_oe),
    .alt3_out_i (alt3_out), .alt3_oe_i (alt3_oe),
    .pad_err_o (pad_err), .rd_err_o (rd_err), .rst_err_o (rst_err), .xfer_cnt_o (xfer_cnt)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rnd_state = xorshift(rnd_state);
    v = rnd_state;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge wMEM_CLK);
      #1;
    end
  endtask

  // one APB transfer, returns 1 ns after the completing edge
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t data);
    logic ok;
    issued++;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge wMEM_CLK);
    #1;
    penable = 1'b1;
    ok = 1'b0;
    while (!ok)
    begin
      @(negedge wMEM_CLK);
      ok = pready;
    end
    @(posedge wMEM_CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  initial
  begin
    wMEM_CLK = 1'b0;
    forever #(CLK_PERIOD / 2) wMEM_CLK = ~wMEM_CLK;
  end

  // alternate sources change every cycle once enabled
  initial
  begin
    forever
    begin
      @(posedge wMEM_CLK);
      #1;
      if (alt_run)
      begin
        alt_state = xorshift(alt_state);
        alt1_out  = alt_state;
        alt_state = xorshift(alt_state);
        alt2_out  = alt_state;
        alt_state = xorshift(alt_state);
        alt2_oe   = alt_state;
        alt_state = xorshift(alt_state);
        alt3_out  = alt_state;
        alt_state = xorshift(alt_state);
        alt3_oe   = alt_state;
      end
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin : stimulus
    logic [31:0] r;
    logic [31:0] v;
    int          asrt_err;
    reset_i = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    pad_in = '0;
    {alt1_out, alt2_out, alt2_oe, alt3_out, alt3_oe} = '0;
    alt_run = 1'b0;
    issued = 0;
    rnd_state = 32'(SEED);
    alt_state = xorshift(32'(SEED) ^ 32'h2545f491);
    repeat (RESET_CYCLES) @(posedge wMEM_CLK);
    #1 reset_i = 1'b0;
    do @(negedge wMEM_CLK); while (!pready);  // reset stretch
    idle_cycles(1);
    for (int i = 0; i < N_READBACK; i++)
    begin
      next_rand(r);
      next_rand(v);
      apb_xfer(1'b1, wr_addrs[r[1:0]], v);
      apb_xfer(1'b0, wr_addrs[r[1:0]], '0);
    end
    apb_xfer(1'b1, ADDR_MSEL_LO, '0);  // all pins gpio
    apb_xfer(1'b1, ADDR_MSEL_HI, '0);
    for (int i = 0; i < N_GPIO; i++)
    begin
      next_rand(r);
      next_rand(v);
      apb_xfer(1'b1, r[0] ? ADDR_DIR : ADDR_OUT, v);
      idle_cycles(2);
    end
    alt_run = 1'b1;
    for (int i = 0; i < N_ALT; i++)
    begin
      next_rand(v);
      apb_xfer(1'b1, ADDR_MSEL_LO, v);
      next_rand(v);
      apb_xfer(1'b1, ADDR_MSEL_HI, v);
      idle_cycles(ALT_HOLD);
    end
    for (int i = 0; i < N_INPUT; i++)
    begin
      next_rand(v);
      pad_in = v;
      idle_cycles(5);
      apb_xfer(1'b0, ADDR_IN, '0);
    end
    next_rand(v);
    apb_xfer(1'b1, ADDR_IN, v);  // read only offset
    next_rand(v);
    apb_xfer(1'b1, 8'h20, v);    // unmapped
    apb_xfer(1'b0, 8'h20, '0);
    for (int i = 0; i < 4; i++)
    begin
      apb_xfer(1'b0, wr_addrs[i], '0);
    end
    idle_cycles(4);
    asrt_err = i_dut.i_pio_apb_regs.i_assertions.fail_cnt;
    $display("errors: pads %0d, reads %0d, reset %0d, assertions %0d; transfers %0d of %0d",
             pad_err, rd_err, rst_err, asrt_err, xfer_cnt, issued);
    if (pad_err == 0 && rd_err == 0 && rst_err == 0 && asrt_err == 0 && xfer_cnt == issued)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== pio_top.f ====
verilog/pio_pkg.sv
verilog/reset_stretch.sv
verilog/pio_apb_regs.sv
verilog/pin_mux.sv
verilog/pio_top.sv
verification/pio_assertions.sv
verification/pio_checker.sv
verification/pio_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pio_top testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f pio_top.f --top-module pio_tb \
  -Mdir obj_dir -o pio_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

# the error limit lets the run reach the closing line after an assertion fails
./obj_dir/pio_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
